// File: verilog/pipe_pkg.sv
package pipe_pkg;

    // default widths for the top level parameters
    localparam int NB_DATA_DEF = 32;
    localparam int NB_ADDR_DEF = 8;     // 256 data words
    localparam int NB_REG_ADDR = 5;     // 32 registers

    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_ADD   = 3'd1,
        OP_ADDI  = 3'd2,
        OP_LOAD  = 3'd3,
        OP_STORE = 3'd4
    } op_e;

    typedef enum logic [1:0] {
        W_BYTE = 2'b00,
        W_HALF = 2'b01,
        W_WORD = 2'b10
    } width_e;

    // decoded operation with operands already read
    typedef struct packed {
        op_e                    op;
        logic [NB_DATA_DEF-1:0] rs_val;
        logic [NB_DATA_DEF-1:0] rt_val;
        logic [15:0]            imm;
        logic [NB_REG_ADDR-1:0] rd;
        width_e                 width;
        logic                   sign;     // 1 = sign-extend
    } op_req_t;

    // execute to memory bundle
    typedef struct packed {
        logic [NB_DATA_DEF-1:0] result;      // alu result or effective address
        logic [NB_DATA_DEF-1:0] store_data;
        logic [NB_REG_ADDR-1:0] rd;
        width_e                 width;
        logic                   sign;
        logic                   mem_write;
        logic                   mem2reg;
        logic                   reg_write;
    } ex_mem_t;

    // memory to write-back bundle
    typedef struct packed {
        logic [NB_DATA_DEF-1:0] load_data;
        logic [NB_DATA_DEF-1:0] alu_result;
        logic [NB_REG_ADDR-1:0] rd;
        logic                   mem2reg;
        logic                   reg_write;
    } mem_wb_t;

endpackage

// File: verilog/addr_gen_stage.sv
`timescale 1ns/1ps

module addr_gen_stage
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_halt,
    input  op_req_t i_op,
    output ex_mem_t o_ex_mem
);

    logic [NB_DATA_DEF-1:0] imm_ext;
    logic [NB_DATA_DEF-1:0] operand_b;
    logic                   mem_write;
    logic                   mem2reg;
    logic                   reg_write;
    ex_mem_t                ex_next;
    ex_mem_t                ex_q;

    assign imm_ext = {{(NB_DATA_DEF-16){i_op.imm[15]}}, i_op.imm};

    // opcode decode
    always_comb begin : decode
        operand_b = imm_ext;     // addi, load and store use the immediate
        mem_write = 1'b0;
        mem2reg   = 1'b0;
        reg_write = 1'b0;
        case (i_op.op)
            OP_ADD: begin
                operand_b = i_op.rt_val;
                reg_write = 1'b1;
            end
            OP_ADDI: begin
                reg_write = 1'b1;
            end
            OP_LOAD: begin
                mem2reg   = 1'b1;
                reg_write = 1'b1;
            end
            OP_STORE: begin
                mem_write = 1'b1;
            end
            default: begin
                // nop writes nothing
                mem_write = 1'b0;
            end
        endcase
    end

    always_comb begin
        ex_next            = '0;
        ex_next.result     = i_op.rs_val + operand_b;
        ex_next.store_data = i_op.rt_val;     // only meaningful for stores
        ex_next.rd         = i_op.rd;
        ex_next.width      = i_op.width;
        ex_next.sign       = i_op.sign;
        ex_next.mem_write  = mem_write;
        ex_next.mem2reg    = mem2reg;
        ex_next.reg_write  = reg_write;
    end

    // execute bundle register, frozen while halted
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex_q <= '0;
        end else if (!i_halt) begin
            ex_q <= ex_next;
        end
    end

    assign o_ex_mem = ex_q;

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int NB_DATA = 32,
    parameter int NB_ADDR = 8
) (
    input  logic               clk,
    input  logic               i_we,
    input  logic [NB_ADDR-1:0] i_addr,
    input  logic [NB_DATA-1:0] i_data,
    output logic [NB_DATA-1:0] o_data
);

    localparam int DEPTH = 2**NB_ADDR;

    logic [NB_DATA-1:0] mem [DEPTH];

    // clocked write
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_data;
        end
    end

    // read is combinational, so a load right after a store sees the new word
    assign o_data = mem[i_addr];

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import pipe_pkg::*;
#(
    parameter int NB_DATA = NB_DATA_DEF,
    parameter int NB_ADDR = NB_ADDR_DEF
) (
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_halt,
    input  ex_mem_t i_ex_mem,
    output mem_wb_t o_mem_wb
);

    logic [NB_DATA-1:0] store_fmt;
    logic [NB_DATA-1:0] ram_rdata;
    logic [NB_DATA-1:0] load_fmt;
    logic [NB_ADDR-1:0] ram_addr;
    logic               ram_we;
    mem_wb_t            wb_next;
    mem_wb_t            wb_q;

    // low byte or half kept and extended by sign
    function automatic logic [NB_DATA-1:0] fmt_width(
        input logic [NB_DATA-1:0] data,
        input width_e             width,
        input logic               sign
    );
        logic ext_bit;
        ext_bit = 1'b0;
        case (width)
            W_BYTE: begin
                ext_bit = sign & data[7];
                return {{(NB_DATA-8){ext_bit}}, data[7:0]};
            end
            W_HALF: begin
                ext_bit = sign & data[15];
                return {{(NB_DATA-16){ext_bit}}, data[15:0]};
            end
            default: begin
                return data;     // word and the unused encoding
            end
        endcase
    endfunction

    assign ram_addr  = i_ex_mem.result[NB_ADDR-1:0];
    assign ram_we    = i_ex_mem.mem_write & ~i_halt;    // no write while frozen
    assign store_fmt = fmt_width(i_ex_mem.store_data, i_ex_mem.width, i_ex_mem.sign);

    // narrow stores still write the full word
    data_ram #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) u_data_ram (
        .clk    (clk),
        .i_we   (ram_we),
        .i_addr (ram_addr),
        .i_data (store_fmt),
        .o_data (ram_rdata)
    );

    assign load_fmt = fmt_width(ram_rdata, i_ex_mem.width, i_ex_mem.sign);

    always_comb begin
        wb_next            = '0;
        wb_next.load_data  = load_fmt;
        wb_next.alu_result = i_ex_mem.result;
        wb_next.rd         = i_ex_mem.rd;
        wb_next.mem2reg    = i_ex_mem.mem2reg;
        wb_next.reg_write  = i_ex_mem.reg_write;
    end

    // write-back bundle register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_q <= '0;
        end else if (!i_halt) begin
            wb_q <= wb_next;
        end
    end

    assign o_mem_wb = wb_q;

endmodule

// File: verilog/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import pipe_pkg::*;
#(
    parameter int NB_DATA = NB_DATA_DEF
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_halt,
    input  mem_wb_t                i_mem_wb,
    input  logic [NB_REG_ADDR-1:0] i_rf_raddr,
    output logic [NB_DATA-1:0]     o_rf_rdata
);

    localparam int NUM_REGS = 2**NB_REG_ADDR;

    logic [NB_DATA-1:0] rf [NUM_REGS];
    logic [NB_DATA-1:0] wb_data;
    logic               rf_we;

    // loaded word or alu result
    assign wb_data = i_mem_wb.mem2reg ? i_mem_wb.load_data : i_mem_wb.alu_result;

    // r0 is never written
    assign rf_we = i_mem_wb.reg_write & ~i_halt & (i_mem_wb.rd != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[i_mem_wb.rd] <= wb_data;
        end
    end

    // debug read port
    always_comb begin
        if (i_rf_raddr == '0) begin
            o_rf_rdata = '0;     // r0 reads zero
        end else begin
            o_rf_rdata = rf[i_rf_raddr];
        end
    end

endmodule

// File: verilog/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top
    import pipe_pkg::*;
#(
    parameter int NB_DATA = NB_DATA_DEF,
    parameter int NB_ADDR = NB_ADDR_DEF
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_halt,
    input  op_req_t                i_op,
    input  logic [NB_REG_ADDR-1:0] i_rf_raddr,
    output logic [NB_DATA-1:0]     o_rf_rdata
);

    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // execute: alu result or effective address
    addr_gen_stage u_addr_gen (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_halt   (i_halt),
        .i_op     (i_op),
        .o_ex_mem (ex_mem)
    );

    // memory access and data formatting
    mem_stage #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) u_mem_stage (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_halt   (i_halt),
        .i_ex_mem (ex_mem),
        .o_mem_wb (mem_wb)
    );

    // register file write and debug read
    writeback_stage #(
        .NB_DATA (NB_DATA)
    ) u_writeback (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_halt     (i_halt),
        .i_mem_wb   (mem_wb),
        .i_rf_raddr (i_rf_raddr),
        .o_rf_rdata (o_rf_rdata)
    );

endmodule

// File: testbench/tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb
    import pipe_pkg::*;
();

    localparam int N_FILL     = 256;    // one word store per memory address
    localparam int N_RAND     = 400;
    localparam int N_AROUND   = 40;     // random ops on each side of the halt
    localparam int N_HALT     = 6;
    localparam int N_DIRECTED = 80;
    localparam int MAX_CYCLES = 8 + 2 * 32 + N_FILL + N_DIRECTED + N_RAND
                              + 2 * N_AROUND + N_HALT + 100;

    logic                   clk;
    logic                   i_rst_n;
    logic                   i_halt;
    op_req_t                i_op;
    logic [NB_REG_ADDR-1:0] i_rf_raddr;
    logic [NB_DATA_DEF-1:0] o_rf_rdata;

    // reference model state
    logic [31:0] model_rf [32];
    logic [31:0] model_mem [256];
    op_req_t     pipe [3];      // 0 driven, 1 in execute, 2 in write-back
    logic [31:0] wb_val;        // value that pipe[2] writes back
    logic        halt_q;        // halt level seen at the next edge
    logic [4:0]  last_rd;       // last register the model wrote
    int          seed = 32'h8c98_3f6f;
    int          cycle_cnt = 0;
    int          n_checks = 0;

    mem_wb_top #(
        .NB_DATA (NB_DATA_DEF),
        .NB_ADDR (NB_ADDR_DEF)
    ) u_dut (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_halt     (i_halt),
        .i_op       (i_op),
        .i_rf_raddr (i_rf_raddr),
        .o_rf_rdata (o_rf_rdata)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("TIMEOUT: test did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "run limit reached");
        end
    end

    // debug port sampled mid-cycle away from the clock edge
    always @(negedge clk) begin : rf_check
        logic [31:0] expected;
        if (i_rst_n === 1'b1) begin
            expected = (i_rf_raddr == 5'd0) ? 32'h0 : model_rf[i_rf_raddr];
            n_checks++;
            assert (o_rf_rdata === expected) else begin
                $display("ERROR at %0t: r%0d reads %h, expected %h",
                         $time, i_rf_raddr, o_rf_rdata, expected);
                $display("SIMULATION FAILED");
                $fatal(1, "register file mismatch");
            end
        end
    end

    function automatic op_req_t build_op(
        input op_e         code,
        input logic [31:0] rs,
        input logic [31:0] rt,
        input logic [15:0] imm,
        input logic [4:0]  rd,
        input width_e      w,
        input logic        s
    );
        op_req_t op;
        op.op     = code;
        op.rs_val = rs;
        op.rt_val = rt;
        op.imm    = imm;
        op.rd     = rd;
        op.width  = w;
        op.sign   = s;
        return op;
    endfunction

    // byte and half keep the low bits and sign picks ones or zeros above
    function automatic logic [31:0] extend_to_width(
        input logic [31:0] data,
        input width_e      w,
        input logic        s
    );
        logic [31:0] kept;
        logic [31:0] upper;
        logic        top_bit;
        case (w)
            W_BYTE: begin
                kept    = data & 32'h0000_00ff;
                upper   = 32'hffff_ff00;
                top_bit = data[7];
            end
            W_HALF: begin
                kept    = data & 32'h0000_ffff;
                upper   = 32'hffff_0000;
                top_bit = data[15];
            end
            default: begin
                kept    = data;
                upper   = 32'h0;
                top_bit = 1'b0;
            end
        endcase
        if (s && top_bit) begin
            return kept | upper;
        end
        return kept;
    endfunction

    function automatic logic [31:0] op_result(input op_req_t op);
        logic [31:0] imm32;
        imm32 = {{16{op.imm[15]}}, op.imm};
        if (op.op == OP_ADD) begin
            return op.rs_val + op.rt_val;
        end
        return op.rs_val + imm32;     // addi, and the address of loads and stores
    endfunction

    function automatic logic writes_reg(input op_req_t op);
        return (op.op == OP_ADD) || (op.op == OP_ADDI) || (op.op == OP_LOAD);
    endfunction

    function automatic op_req_t random_fields(input op_e code);
        op_req_t     op;
        logic [31:0] r;
        logic [7:0]  wsel;
        op.op     = code;
        op.rs_val = $random(seed);
        op.rt_val = $random(seed);
        r         = $random(seed);
        wsel      = r[31:24] % 8'd3;
        op.imm    = r[15:0];
        op.rd     = r[20:16];
        op.width  = width_e'(wsel[1:0]);
        op.sign   = r[21];
        return op;
    endfunction

    function automatic op_req_t random_op();
        logic [31:0] r;
        logic [31:0] sel;
        r   = $random(seed);
        sel = r % 32'd5;
        return random_fields(op_e'(sel[2:0]));
    endfunction

    // one clock edge of the reference pipeline
    task automatic advance_model();
        logic [31:0] res;
        logic [7:0]  addr;
        logic [31:0] next_val;
        if (!halt_q) begin
            if (writes_reg(pipe[2]) && pipe[2].rd != 5'd0) begin
                model_rf[pipe[2].rd] = wb_val;
                last_rd = pipe[2].rd;
            end
            res  = op_result(pipe[1]);
            addr = res[7:0];
            if (pipe[1].op == OP_STORE) begin
                model_mem[addr] = extend_to_width(pipe[1].rt_val, pipe[1].width, pipe[1].sign);
            end
            if (pipe[1].op == OP_LOAD) begin
                next_val = extend_to_width(model_mem[addr], pipe[1].width, pipe[1].sign);
            end else begin
                next_val = res;
            end
            pipe[2] = pipe[1];
            wb_val  = next_val;
            pipe[1] = pipe[0];
        end
    endtask

    // raddr below zero follows the register written on this edge
    task automatic issue(input op_req_t op, input int raddr);
        @(posedge clk);
        advance_model();
        pipe[0] = op;
        i_op <= op;
        if (raddr < 0) begin
            i_rf_raddr <= last_rd;
        end else begin
            i_rf_raddr <= raddr[4:0];
        end
    endtask

    task automatic idle(input int n, input int raddr);
        repeat (n) begin
            issue(random_fields(OP_NOP), raddr);
        end
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < 32; i++) begin
            issue(random_fields(OP_NOP), i);
        end
    endtask

    // drives op with halt raised and holds it for n edges
    // the debug port watches the register that write-back holds back
    task automatic hold_halt(input op_req_t op, input int n);
        @(posedge clk);
        advance_model();
        pipe[0] = op;
        i_op       <= op;
        i_halt     <= 1'b1;
        i_rf_raddr <= pipe[2].rd;
        halt_q      = 1'b1;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            advance_model();     // frozen, model keeps its state
            i_rf_raddr <= pipe[2].rd;
            if (i == n - 1) begin
                i_halt <= 1'b0;
                halt_q  = 1'b0;
            end
        end
    endtask

    initial begin : stimulus
        logic [31:0] word;
        logic [4:0]  dst;
        op_req_t     op_a;
        op_req_t     op_s;
        op_req_t     op_l;
        clk        = 1'b0;
        i_rst_n    = 1'b0;
        i_halt     = 1'b0;
        i_op       = '0;
        i_rf_raddr = '0;
        halt_q     = 1'b0;
        wb_val     = '0;
        last_rd    = '0;
        for (int i = 0; i < 3; i++) begin
            pipe[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        repeat (8) @(posedge clk);
        i_rst_n <= 1'b1;

        // all registers read zero after reset while random nops flow
        sweep_regs();

        // every word gets a known value before any load
        for (int a = 0; a < N_FILL; a++) begin
            word = $random(seed);
            issue(build_op(OP_STORE, a, word, 16'h0000, 5'd0, W_WORD, 1'b0), -1);
        end

        // destination held on the debug port across the write edge
        issue(build_op(OP_ADD, 32'd100, 32'd23, 16'h0000, 5'd5, W_WORD, 1'b0), 5);
        idle(4, 5);
        issue(build_op(OP_ADDI, 32'h0000_1000, 32'h0, 16'hfffd, 5'd6, W_WORD, 1'b0), 6);
        idle(4, 6);
        issue(build_op(OP_ADDI, 32'hffff_fff0, 32'h0, 16'h7fff, 5'd7, W_WORD, 1'b0), 7);
        idle(4, 7);
        issue(build_op(OP_ADD, 32'h55, 32'h66, 16'h0000, 5'd0, W_WORD, 1'b0), 0);
        idle(4, 0);     // r0 stays zero

        // load right behind a store to the same word
        issue(build_op(OP_STORE, 32'h40, 32'hdead_beef, 16'h0005, 5'd0, W_WORD, 1'b0), -1);
        issue(build_op(OP_LOAD, 32'h40, 32'h0, 16'h0005, 5'd9, W_WORD, 1'b0), -1);
        issue(build_op(OP_STORE, 32'h100, 32'h1234_5678, 16'hfffc, 5'd0, W_WORD, 1'b0), -1);
        issue(build_op(OP_LOAD, 32'h0, 32'h0, 16'h00fc, 5'd10, W_WORD, 1'b0), -1);
        issue(build_op(OP_LOAD, 32'h145, 32'h0, 16'h0000, 5'd11, W_WORD, 1'b0), -1);
        idle(3, -1);

        // narrow stores put the extended value in the whole word
        issue(build_op(OP_STORE, 32'h10, 32'h1234_56a5, 16'h0, 5'd0, W_BYTE, 1'b1), -1);
        issue(build_op(OP_STORE, 32'h11, 32'h1234_56a5, 16'h0, 5'd0, W_BYTE, 1'b0), -1);
        issue(build_op(OP_STORE, 32'h12, 32'h0000_8001, 16'h0, 5'd0, W_HALF, 1'b1), -1);
        issue(build_op(OP_STORE, 32'h13, 32'h0000_8001, 16'h0, 5'd0, W_HALF, 1'b0), -1);
        for (int a = 0; a < 4; a++) begin
            dst = 5'd12 + a[4:0];
            issue(build_op(OP_LOAD, 32'h10 + a, 32'h0, 16'h0, dst, W_WORD, 1'b0), -1);
        end

        // narrow loads of words with the top bits mostly set
        for (int j = 0; j < 4; j++) begin
            word = $random(seed);
            if (j != 3) begin
                word = word | 32'h0000_8080;
            end else begin
                word = word & 32'hffff_7f7f;
            end
            issue(build_op(OP_STORE, 32'h20, word, 16'h0, 5'd0, W_WORD, 1'b0), -1);
            issue(build_op(OP_LOAD, 32'h20, 32'h0, 16'h0, 5'd16, W_BYTE, 1'b1), -1);
            issue(build_op(OP_LOAD, 32'h20, 32'h0, 16'h0, 5'd17, W_BYTE, 1'b0), -1);
            issue(build_op(OP_LOAD, 32'h20, 32'h0, 16'h0, 5'd18, W_HALF, 1'b1), -1);
            issue(build_op(OP_LOAD, 32'h20, 32'h0, 16'h0, 5'd19, W_HALF, 1'b0), -1);
        end
        idle(3, -1);

        // back to back mixed traffic
        for (int i = 0; i < N_RAND; i++) begin
            issue(random_op(), -1);
        end

        // halt with an add, a store and a load of the stored word in flight
        for (int i = 0; i < N_AROUND; i++) begin
            issue(random_op(), -1);
        end
        op_a        = random_fields(OP_ADD);
        op_a.rd     = 5'd20;
        op_s        = random_fields(OP_STORE);
        op_l        = random_fields(OP_LOAD);
        op_l.rs_val = op_s.rs_val;
        op_l.imm    = op_s.imm;
        op_l.rd     = 5'd21;
        issue(op_a, -1);
        issue(op_s, -1);
        hold_halt(op_l, N_HALT);
        for (int i = 0; i < N_AROUND; i++) begin
            issue(random_op(), -1);
        end
        idle(3, -1);
        sweep_regs();

        $display("%0d register reads checked over %0d cycles", n_checks, cycle_cnt);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: vlog.f
verilog/pipe_pkg.sv
verilog/addr_gen_stage.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/writeback_stage.sv
verilog/mem_wb_top.sv
testbench/tb_mem_wb.sv

// File: Makefile
# verilator build and run of the memory and write-back pipeline testbench

SIM := obj_dir/Vtb_mem_wb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): vlog.f $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --assert -j 0 --top-module tb_mem_wb -Mdir obj_dir -f vlog.f

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
